// ==== logic/audio_pkg.sv ====
package audio_pkg;

  // ==========================================================
  // Flash bus
  // ==========================================================

  localparam int ADDR_W = 23;

  // Read to readdatavalid, worst case in clock cycles
  localparam int FLASH_MAX_WAIT = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [31:0]       word_t;

  // Highest word of the sample region
  localparam addr_t LAST_ADDR = 23'h7FFFF;

  typedef struct packed {
    logic  read;
    addr_t address;
  } flash_req_t;

  // ==========================================================
  // Samples and playback control
  // ==========================================================

  // Taken from bits 15 to 8 of each flash word
  typedef logic signed [7:0] sample_t;

  typedef struct packed {
    logic play;
    logic forward;
  } play_ctrl_t;

endpackage

// ==== logic/ui_pkg.sv ====
package ui_pkg;

  // ==========================================================
  // Keyboard
  // ==========================================================

  typedef logic [7:0] scan_code_t;

  // Keys E, D, F and B
  localparam scan_code_t SCAN_PLAY     = 8'h24;
  localparam scan_code_t SCAN_PAUSE    = 8'h23;
  localparam scan_code_t SCAN_FORWARD  = 8'h2B;
  localparam scan_code_t SCAN_BACKWARD = 8'h32;

  // ==========================================================
  // Sample-rate divider
  // ==========================================================

  typedef logic [15:0] div_t;

  // About 44 kHz from the 50 MHz clock
  localparam div_t DEFAULT_DIV = 16'd1136;
  localparam div_t SPEED_STEP  = 16'd100;

  // Clamp bounds, MIN_DIV stays well above the flash latency
  localparam div_t MIN_DIV = 16'd136;
  localparam div_t MAX_DIV = 16'd2136;

  // ==========================================================
  // Seven-segment display
  // ==========================================================

  localparam int DIGITS = 6;

  // Active low, bit 0 is segment a and bit 6 is segment g
  typedef logic [6:0] seg_t;

  // Digit 0 is the least significant nibble
  typedef seg_t [DIGITS-1:0] hex_bus_t;

endpackage

// ==== logic/kbd_command_decode.sv ====
`timescale 1ns/1ps

module kbd_command_decode (
  input  logic                  CLK_50M,
  input  logic                  reset,
  input  ui_pkg::scan_code_t    kbd_scan,
  input  logic                  kbd_valid,
  output audio_pkg::play_ctrl_t play_ctrl
);

  // Paused and forward out of reset
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      play_ctrl.play    <= 1'b0;
      play_ctrl.forward <= 1'b1;
    end
    else if (kbd_valid)
    begin
      case (kbd_scan)
        ui_pkg::SCAN_PLAY:     play_ctrl.play    <= 1'b1;
        ui_pkg::SCAN_PAUSE:    play_ctrl.play    <= 1'b0;
        ui_pkg::SCAN_FORWARD:  play_ctrl.forward <= 1'b1;
        ui_pkg::SCAN_BACKWARD: play_ctrl.forward <= 1'b0;
        // Everything else leaves the state alone
        default:
        begin
          play_ctrl <= play_ctrl;
        end
      endcase
    end
  end

endmodule

// ==== logic/speed_control.sv ====
`timescale 1ns/1ps

module speed_control (
  input  logic         CLK_50M,
  input  logic         reset,
  input  logic         speed_up_key,
  input  logic         speed_down_key,
  input  logic         speed_reset_key,
  output ui_pkg::div_t div_count
);

  // Bit order {reset, down, up}
  logic [2:0] key_meta;
  logic [2:0] key_sync;
  logic [2:0] key_prev;
  logic [2:0] key_rise;

  // ==========================================================
  // Two-flop synchronizer and edge history
  // ==========================================================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      key_meta <= '0;
      key_sync <= '0;
      key_prev <= '0;
    end
    else
    begin
      key_meta <= {speed_reset_key, speed_down_key, speed_up_key};
      key_sync <= key_meta;
      key_prev <= key_sync;
    end
  end

  assign key_rise = key_sync & ~key_prev;

  // ==========================================================
  // Divider count
  // ==========================================================

  // Reset key wins, then up, then down
  // A step past either bound is dropped
  always_ff @(posedge CLK_50M)
  begin
    if (reset || key_rise[2])
      div_count <= ui_pkg::DEFAULT_DIV;
    else if (key_rise[0])
    begin
      if (div_count >= ui_pkg::MIN_DIV + ui_pkg::SPEED_STEP)
        div_count <= div_count - ui_pkg::SPEED_STEP;
    end
    else if (key_rise[1])
    begin
      if (div_count <= ui_pkg::MAX_DIV - ui_pkg::SPEED_STEP)
        div_count <= div_count + ui_pkg::SPEED_STEP;
    end
  end

  // The tick period must never fall below the flash read time
  a_div_in_range: assert property (@(posedge CLK_50M) disable iff (reset)
    div_count >= ui_pkg::MIN_DIV && div_count <= ui_pkg::MAX_DIV)
    else $error("divider count %0d out of range", div_count);

endmodule

// ==== logic/sample_tick_gen.sv ====
`timescale 1ns/1ps

module sample_tick_gen (
  input  logic                  CLK_50M,
  input  logic                  reset,
  input  audio_pkg::play_ctrl_t play_ctrl,
  input  ui_pkg::div_t          div_count,
  output logic                  tick
);

  ui_pkg::div_t period_cnt;

  // One tick per div_count cycles while playing
  always_ff @(posedge CLK_50M)
  begin
    if (reset || !play_ctrl.play)
    begin
      period_cnt <= '0;
      tick       <= 1'b0;
    end
    // Greater-or-equal also catches a period shortened mid-count
    else if (period_cnt >= div_count - 16'd1)
    begin
      period_cnt <= '0;
      tick       <= 1'b1;
    end
    else
    begin
      period_cnt <= period_cnt + 16'd1;
      tick       <= 1'b0;
    end
  end

endmodule

// ==== logic/flash_address_seq.sv ====
`timescale 1ns/1ps

module flash_address_seq (
  input  logic                  CLK_50M,
  input  logic                  reset,
  input  logic                  tick,
  input  audio_pkg::play_ctrl_t play_ctrl,
  output logic                  fetch,
  output audio_pkg::addr_t      fetch_addr
);

  audio_pkg::addr_t next_addr;

  // Address walk, wraps at both ends of the sample region
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      fetch     <= 1'b0;
      next_addr <= '0;
    end
    else
    begin
      fetch <= tick;
      if (tick)
      begin
        if (play_ctrl.forward)
          next_addr <= (next_addr == audio_pkg::LAST_ADDR) ? '0 : next_addr + 1'b1;
        else
          next_addr <= (next_addr == '0) ? audio_pkg::LAST_ADDR : next_addr - 1'b1;
      end
    end
  end

  // Fetch carries the address held before the step
  always_ff @(posedge CLK_50M)
  begin
    if (tick)
      fetch_addr <= next_addr;
  end

endmodule

// ==== logic/flash_reader.sv ====
`timescale 1ns/1ps

module flash_reader (
  input  logic                  CLK_50M,
  input  logic                  reset,
  input  logic                  fetch,
  input  audio_pkg::addr_t      fetch_addr,
  output audio_pkg::flash_req_t flash_req,
  input  logic                  flash_waitrequest,
  input  audio_pkg::word_t      flash_readdata,
  input  logic                  flash_readdatavalid,
  output audio_pkg::sample_t    sample,
  output logic                  sample_valid
);

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    AWAIT_DATA
  } state_t;

  state_t                                             state;
  logic                                               read_q;
  audio_pkg::addr_t                                   addr_q;
  logic [$clog2(audio_pkg::FLASH_MAX_WAIT + 2)-1:0]   busy_cnt;

  assign flash_req.read    = read_q;
  assign flash_req.address = addr_q;

  // ==========================================================
  // Read transaction FSM
  // ==========================================================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state        <= IDLE;
      read_q       <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      case (state)
        IDLE:
        begin
          if (fetch)
          begin
            read_q <= 1'b1;
            state  <= REQUEST;
          end
        end
        // Hold read until the slave drops waitrequest
        REQUEST:
        begin
          if (!flash_waitrequest)
          begin
            read_q <= 1'b0;
            state  <= AWAIT_DATA;
          end
        end
        AWAIT_DATA:
        begin
          if (flash_readdatavalid)
          begin
            sample_valid <= 1'b1;
            state        <= IDLE;
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (state == IDLE && fetch)
      addr_q <= fetch_addr;
    if (state == AWAIT_DATA && flash_readdatavalid)
      sample <= flash_readdata[15:8];
  end

  // Cycles spent on the current transaction
  always_ff @(posedge CLK_50M)
  begin
    if (reset || state == IDLE)
      busy_cnt <= '0;
    else
      busy_cnt <= busy_cnt + 1'b1;
  end

  // ==========================================================
  // Bus checks
  // ==========================================================

  // Tick period must cover a whole read
  a_no_fetch_busy: assert property (@(posedge CLK_50M) disable iff (reset)
    fetch |-> state == IDLE)
    else $error("fetch arrived while a flash read was outstanding");

  a_addr_stable: assert property (@(posedge CLK_50M) disable iff (reset)
    flash_req.read && flash_waitrequest |=> flash_req.read && $stable(flash_req.address))
    else $error("flash read dropped or address changed under waitrequest");

  a_read_latency: assert property (@(posedge CLK_50M) disable iff (reset)
    busy_cnt <= audio_pkg::FLASH_MAX_WAIT)
    else $error("flash read took longer than %0d cycles", audio_pkg::FLASH_MAX_WAIT);

endmodule

// ==== logic/hex_display.sv ====
`timescale 1ns/1ps

module hex_display (
  input  logic             CLK_50M,
  input  logic             reset,
  input  ui_pkg::div_t     div_count,
  output ui_pkg::hex_bus_t hex
);

  logic [4*ui_pkg::DIGITS-1:0] nibbles;

  // Active-low font, segments g..a
  function automatic ui_pkg::seg_t hex_glyph(input logic [3:0] value);
    case (value)
      4'h0: hex_glyph = 7'b1000000;
      4'h1: hex_glyph = 7'b1111001;
      4'h2: hex_glyph = 7'b0100100;
      4'h3: hex_glyph = 7'b0110000;
      4'h4: hex_glyph = 7'b0011001;
      4'h5: hex_glyph = 7'b0010010;
      4'h6: hex_glyph = 7'b0000010;
      4'h7: hex_glyph = 7'b1111000;
      4'h8: hex_glyph = 7'b0000000;
      4'h9: hex_glyph = 7'b0010000;
      4'hA: hex_glyph = 7'b0001000;
      4'hB: hex_glyph = 7'b0000011;
      4'hC: hex_glyph = 7'b1000110;
      4'hD: hex_glyph = 7'b0100001;
      4'hE: hex_glyph = 7'b0000110;
      default: hex_glyph = 7'b0001110;
    endcase
  endfunction

  // Upper digits read zero
  assign nibbles = {{(4*ui_pkg::DIGITS-$bits(ui_pkg::div_t)){1'b0}}, div_count};

  // Blank while in reset
  always_ff @(posedge CLK_50M)
  begin
    for (int i = 0; i < ui_pkg::DIGITS; i++)
    begin
      hex[i] <= reset ? '1 : hex_glyph(nibbles[4*i +: 4]);
    end
  end

endmodule

// ==== logic/ipod_player_top.sv ====
`timescale 1ns/1ps

module ipod_player_top (
  input  logic                  CLK_50M,
  input  logic                  reset,
  input  ui_pkg::scan_code_t    kbd_scan,
  input  logic                  kbd_valid,
  input  logic                  speed_up_key,
  input  logic                  speed_down_key,
  input  logic                  speed_reset_key,
  output audio_pkg::flash_req_t flash_req,
  input  logic                  flash_waitrequest,
  input  audio_pkg::word_t      flash_readdata,
  input  logic                  flash_readdatavalid,
  output audio_pkg::sample_t    sample,
  output logic                  sample_valid,
  output ui_pkg::hex_bus_t      hex
);

  audio_pkg::play_ctrl_t play_ctrl;
  ui_pkg::div_t          div_count;
  logic                  tick;
  logic                  fetch;
  audio_pkg::addr_t      fetch_addr;

  // ==========================================================
  // Control
  // ==========================================================

  kbd_command_decode u_kbd_command_decode (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .kbd_scan  (kbd_scan),
    .kbd_valid (kbd_valid),
    .play_ctrl (play_ctrl)
  );

  speed_control u_speed_control (
    .CLK_50M         (CLK_50M),
    .reset           (reset),
    .speed_up_key    (speed_up_key),
    .speed_down_key  (speed_down_key),
    .speed_reset_key (speed_reset_key),
    .div_count       (div_count)
  );

  // ==========================================================
  // Sample path
  // ==========================================================

  sample_tick_gen u_sample_tick_gen (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .play_ctrl (play_ctrl),
    .div_count (div_count),
    .tick      (tick)
  );

  flash_address_seq u_flash_address_seq (
    .CLK_50M    (CLK_50M),
    .reset      (reset),
    .tick       (tick),
    .play_ctrl  (play_ctrl),
    .fetch      (fetch),
    .fetch_addr (fetch_addr)
  );

  flash_reader u_flash_reader (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .fetch               (fetch),
    .fetch_addr          (fetch_addr),
    .flash_req           (flash_req),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample              (sample),
    .sample_valid        (sample_valid)
  );

  hex_display u_hex_display (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .div_count (div_count),
    .hex       (hex)
  );

endmodule

// ==== dv/flash_model.sv ====
`timescale 1ns/1ps

module flash_model (
  input  logic                  CLK_50M,
  input  logic                  reset,
  input  audio_pkg::flash_req_t flash_req,
  output logic                  flash_waitrequest,
  output audio_pkg::word_t      flash_readdata,
  output logic                  flash_readdatavalid
);

  integer           seed;
  int               stall;
  int               latency;
  logic             busy;
  audio_pkg::addr_t held_addr;

  // Bits 15 to 8 hold the sample byte, the other bits mix in the whole address
  function automatic audio_pkg::word_t word_at(input audio_pkg::addr_t addr);
    logic [7:0] mid;
    logic [7:0] low;
    mid = addr[7:0] ^ 8'h5A;
    low = addr[7:0] + addr[15:8] + {1'b0, addr[22:16]};
    return {addr[22:7] ^ 16'hC3A5, mid, low};
  endfunction

  initial
  begin
    seed                = 32'hd56d_64a5;
    stall               = -1;
    latency             = 0;
    busy                = 1'b0;
    held_addr           = '0;
    flash_waitrequest   = 1'b1;
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
  end

  // Bus outputs move on the falling edge
  always @(negedge CLK_50M)
  begin
    if (reset)
    begin
      flash_waitrequest   = 1'b1;
      flash_readdatavalid = 1'b0;
      busy                = 1'b0;
      stall               = -1;
    end
    else
    begin
      flash_waitrequest   = 1'b1;
      flash_readdatavalid = 1'b0;
      if (busy)
      begin
        latency = latency - 1;
        if (latency == 0)
        begin
          flash_readdata      = word_at(held_addr);
          flash_readdatavalid = 1'b1;
          busy                = 1'b0;
        end
      end
      else if (flash_req.read)
      begin
        // 0 to 3 wait states, then 1 to 8 cycles of latency
        if (stall < 0)
          stall = $unsigned($random(seed)) % 4;
        if (stall == 0)
        begin
          flash_waitrequest = 1'b0;
          held_addr         = flash_req.address;
          latency           = 1 + $unsigned($random(seed)) % 8;
          busy              = 1'b1;
          stall             = -1;
        end
        else
          stall = stall - 1;
      end
    end
  end

endmodule

// ==== dv/ipod_player_tb.sv ====
`timescale 1ns/1ps

module ipod_player_tb;

  typedef enum int {OP_SCAN, OP_KEY, OP_SAMPLES, OP_HEX, OP_IDLE, OP_RESET} op_e;

  localparam int KEY_UP    = 0;
  localparam int KEY_DOWN  = 1;
  localparam int KEY_RESET = 2;
  localparam int STEP_WAIT = 4 * int'(ui_pkg::MAX_DIV);

  // Active-low glyphs 0 to F with segments g..a
  localparam ui_pkg::seg_t SEG_FONT [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12,
    7'h02, 7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

  logic                  CLK_50M;
  logic                  reset;
  ui_pkg::scan_code_t    kbd_scan;
  logic                  kbd_valid;
  logic                  speed_up_key;
  logic                  speed_down_key;
  logic                  speed_reset_key;
  audio_pkg::flash_req_t flash_req;
  logic                  flash_waitrequest;
  audio_pkg::word_t      flash_readdata;
  logic                  flash_readdatavalid;
  audio_pkg::sample_t    sample;
  logic                  sample_valid;
  ui_pkg::hex_bus_t      hex;

  op_e                step_op[$];
  int                 step_arg[$];
  int                 step_exp[$];
  string              step_name[$];
  audio_pkg::addr_t   read_addr_q[$];
  audio_pkg::sample_t sample_q[$];
  int                 read_cycles;
  bit                 table_ready;
  audio_pkg::addr_t   exp_addr;
  bit                 exp_fwd;

  ipod_player_top dut0 (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .kbd_scan            (kbd_scan),
    .kbd_valid           (kbd_valid),
    .speed_up_key        (speed_up_key),
    .speed_down_key      (speed_down_key),
    .speed_reset_key     (speed_reset_key),
    .flash_req           (flash_req),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample              (sample),
    .sample_valid        (sample_valid),
    .hex                 (hex)
  );

  flash_model u_flash_model (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .flash_req           (flash_req),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ==========================================================
  // Bus monitor
  // ==========================================================

  always @(posedge CLK_50M)
  begin
    if (!reset && flash_req.read)
      read_cycles = read_cycles + 1;
    if (!reset && flash_req.read && !flash_waitrequest)
      read_addr_q.push_back(flash_req.address);
    if (!reset && sample_valid)
      sample_q.push_back(sample);
  end

  // ==========================================================
  // Checks
  // ==========================================================

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_sample(input string name, input audio_pkg::sample_t expected,
                              input audio_pkg::sample_t actual);
    if (expected !== actual)
      fail_run($sformatf("ERROR %s sample: expected %h, actual %h", name, expected, actual));
  endtask

  task automatic check_hex(input string name, input ui_pkg::hex_bus_t expected,
                           input ui_pkg::hex_bus_t actual);
    if (expected !== actual)
      fail_run($sformatf("ERROR %s hex: expected %h, actual %h", name, expected, actual));
  endtask

  task automatic check_addr(input string name, input audio_pkg::addr_t expected,
                            input audio_pkg::addr_t actual);
    if (expected !== actual)
      fail_run($sformatf("ERROR %s address: expected %h, actual %h", name, expected, actual));
  endtask

  function automatic ui_pkg::hex_bus_t hex_for(input ui_pkg::div_t value);
    ui_pkg::hex_bus_t digits;
    logic [23:0]      wide;
    wide = {8'h00, value};
    for (int d = 0; d < ui_pkg::DIGITS; d++)
      digits[d] = SEG_FONT[wide[4*d +: 4]];
    return digits;
  endfunction

  // Compares one returned sample with the next address in sequence
  task automatic consume_sample(input string name);
    audio_pkg::addr_t   got_addr;
    audio_pkg::sample_t got_sample;
    if (read_addr_q.size() == 0)
      fail_run($sformatf("%s: a sample arrived without an accepted flash read", name));
    got_addr   = read_addr_q.pop_front();
    got_sample = sample_q.pop_front();
    check_addr(name, exp_addr, got_addr);
    check_sample(name, audio_pkg::sample_t'(exp_addr[7:0] ^ 8'h5A), got_sample);
    if (exp_fwd)
      exp_addr = (exp_addr == audio_pkg::LAST_ADDR) ? '0 : exp_addr + 1'b1;
    else
      exp_addr = (exp_addr == '0) ? audio_pkg::LAST_ADDR : exp_addr - 1'b1;
  endtask

  // ==========================================================
  // Stimulus
  // ==========================================================

  task automatic add_step(input op_e op, input int arg, input int exp, input string name);
    step_op.push_back(op);
    step_arg.push_back(arg);
    step_exp.push_back(exp);
    step_name.push_back(name);
  endtask

  task automatic set_key(input int which, input logic level);
    case (which)
      KEY_UP:   speed_up_key = level;
      KEY_DOWN: speed_down_key = level;
      default:  speed_reset_key = level;
    endcase
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (4) @(negedge CLK_50M);
    reset = 1'b0;
    read_addr_q.delete();
    sample_q.delete();
    exp_addr = '0;
    exp_fwd  = 1'b1;
    repeat (2) @(negedge CLK_50M);
  endtask

  task automatic apply_step(input op_e op, input int arg, input int exp, input string name);
    int waited;
    int snapshot;
    case (op)
      OP_SCAN:
      begin
        kbd_scan  = ui_pkg::scan_code_t'(arg);
        kbd_valid = 1'b1;
        @(negedge CLK_50M);
        kbd_valid = 1'b0;
        if (arg == int'(ui_pkg::SCAN_FORWARD))
          exp_fwd = 1'b1;
        if (arg == int'(ui_pkg::SCAN_BACKWARD))
          exp_fwd = 1'b0;
      end
      OP_KEY:
      begin
        set_key(arg, 1'b1);
        // Two sync stages, edge register, display register
        repeat (4) @(negedge CLK_50M);
        check_hex(name, hex_for(ui_pkg::div_t'(exp)), hex);
        set_key(arg, 1'b0);
        repeat (4) @(negedge CLK_50M);
        if (sample_q.size() != 0)
          fail_run($sformatf("%s: a sample arrived while playback was paused", name));
      end
      OP_SAMPLES:
      begin
        for (int n = 0; n < arg; n++)
        begin
          waited = 0;
          while (sample_q.size() == 0)
          begin
            if (waited == STEP_WAIT)
              fail_run($sformatf("%s: sample %0d never arrived", name, n));
            @(negedge CLK_50M);
            waited++;
          end
          consume_sample(name);
        end
      end
      OP_HEX:
        check_hex(name, hex_for(ui_pkg::div_t'(exp)), hex);
      OP_IDLE:
      begin
        // A read already under way may still finish within the grace cycles
        repeat (exp) @(negedge CLK_50M);
        while (sample_q.size() != 0)
          consume_sample(name);
        snapshot = read_cycles;
        repeat (arg) @(negedge CLK_50M);
        if (read_cycles != snapshot || sample_q.size() != 0)
          fail_run($sformatf("%s: the flash was read while playback was paused", name));
      end
      default:
        apply_reset();
    endcase
  endtask

  task automatic build_table();
    int div_exp;
    add_step(OP_HEX, 0, int'(ui_pkg::DEFAULT_DIV), "reset_hex");
    add_step(OP_IDLE, 3000, 0, "reset_idle");
    add_step(OP_SCAN, int'(ui_pkg::SCAN_PLAY), 0, "play");
    add_step(OP_SAMPLES, 5, 0, "forward_samples");
    add_step(OP_SCAN, int'(ui_pkg::SCAN_PAUSE), 0, "pause");
    add_step(OP_IDLE, 2000, audio_pkg::FLASH_MAX_WAIT + 4, "pause_idle");
    add_step(OP_SCAN, int'(ui_pkg::SCAN_PLAY), 0, "resume");
    add_step(OP_SAMPLES, 3, 0, "resume_samples");
    add_step(OP_RESET, 0, 0, "second_reset");
    add_step(OP_SCAN, int'(ui_pkg::SCAN_BACKWARD), 0, "backward");
    add_step(OP_SCAN, int'(ui_pkg::SCAN_PLAY), 0, "play_backward");
    add_step(OP_SAMPLES, 3, 0, "backward_samples");
    add_step(OP_SCAN, int'(ui_pkg::SCAN_PAUSE), 0, "pause_backward");
    add_step(OP_IDLE, 200, audio_pkg::FLASH_MAX_WAIT + 4, "speed_idle");
    add_step(OP_KEY, KEY_UP, int'(ui_pkg::DEFAULT_DIV - ui_pkg::SPEED_STEP), "speed_up");
    add_step(OP_KEY, KEY_RESET, int'(ui_pkg::DEFAULT_DIV), "speed_restore");
    add_step(OP_KEY, KEY_DOWN, int'(ui_pkg::DEFAULT_DIV + ui_pkg::SPEED_STEP), "speed_down");
    add_step(OP_KEY, KEY_RESET, int'(ui_pkg::DEFAULT_DIV), "speed_restore");
    // Clamp runs in both directions with the last press dropped
    div_exp = int'(ui_pkg::DEFAULT_DIV);
    for (int k = 0; k < 11; k++)
    begin
      if (div_exp + int'(ui_pkg::SPEED_STEP) <= int'(ui_pkg::MAX_DIV))
        div_exp += int'(ui_pkg::SPEED_STEP);
      add_step(OP_KEY, KEY_DOWN, div_exp, $sformatf("down_to_max_%0d", k));
    end
    add_step(OP_KEY, KEY_RESET, int'(ui_pkg::DEFAULT_DIV), "restore_after_max");
    div_exp = int'(ui_pkg::DEFAULT_DIV);
    for (int k = 0; k < 11; k++)
    begin
      if (div_exp - int'(ui_pkg::SPEED_STEP) >= int'(ui_pkg::MIN_DIV))
        div_exp -= int'(ui_pkg::SPEED_STEP);
      add_step(OP_KEY, KEY_UP, div_exp, $sformatf("up_to_min_%0d", k));
    end
    add_step(OP_KEY, KEY_RESET, int'(ui_pkg::DEFAULT_DIV), "restore_after_min");
  endtask

  // ==========================================================
  // Main sequence and watchdog
  // ==========================================================

  initial
  begin
    reset           = 1'b1;
    kbd_scan        = '0;
    kbd_valid       = 1'b0;
    speed_up_key    = 1'b0;
    speed_down_key  = 1'b0;
    speed_reset_key = 1'b0;
    read_cycles     = 0;
    exp_addr        = '0;
    exp_fwd         = 1'b1;
    build_table();
    table_ready = 1'b1;
    apply_reset();
    for (int i = 0; i < step_op.size(); i++)
      apply_step(step_op[i], step_arg[i], step_exp[i], step_name[i]);
    if (read_addr_q.size() == 0 && sample_q.size() == 0)
    begin
      $display("All tests passed!");
      $finish;
    end
    else
    begin
      $display("Flash reads were left without a matching sample");
      $display("Test failures found");
      $fatal(1);
    end
  end

  initial
  begin
    wait (table_ready);
    repeat (step_op.size() * STEP_WAIT) @(posedge CLK_50M);
    $display("Watchdog expired before all test steps finished");
    $display("Test failures found");
    $fatal(1);
  end

endmodule

// ==== sources.f ====
logic/audio_pkg.sv
logic/ui_pkg.sv
logic/kbd_command_decode.sv
logic/speed_control.sv
logic/sample_tick_gen.sv
logic/flash_address_seq.sv
logic/flash_reader.sv
logic/hex_display.sv
logic/ipod_player_top.sv
dv/flash_model.sv
dv/ipod_player_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module ipod_player_tb -Mdir obj_dir -o ipod_player_sim; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/ipod_player_sim 2>&1)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qF 'All tests passed!'; then
  exit 0
fi
exit 1
